//--- src/delay_pkg.sv
`default_nettype none

package delay_pkg;

	////////////////////////////////////////
	// sizes

	localparam int sample_w   = 16;
	localparam int delay_w    = 16;
	localparam int gain_w     = 16;
	localparam int n_lines    = 4;
	localparam int mem_depth  = 256;
	localparam int addr_w     = 8;
	localparam int frac_bits  = 8;  // Q8 delay
	localparam int gain_frac  = 14; // Q14 gain
	localparam int gain_unity = 16384;
	localparam int gain_step  = 64;

	typedef logic signed [sample_w-1:0] sample_t;
	typedef logic        [addr_w-1:0]   addr_t;
	typedef logic        [delay_w-1:0]  delay_t;
	typedef logic signed [delay_w-1:0]  inc_t;
	typedef logic        [gain_w-1:0]   gain_t;
	typedef logic        [1:0]          line_id_t;

	////////////////////////////////////////
	// encodings

	typedef enum logic [1:0] {op_alloc, op_write, op_read} cmd_op_e;
	typedef enum logic [1:0] {st_ok, st_bad_line, st_no_space} resp_status_e;
	typedef enum logic [1:0] {ls_idle, ls_write, ls_fetch} line_state_e;
	typedef enum logic [1:0] {fs_idle, fs_wait_line, fs_gain, fs_ack} front_state_e;

	////////////////////////////////////////
	// bundles

	typedef struct packed {
		cmd_op_e  op;
		line_id_t line;
		addr_t    size;   // alloc only
		delay_t   delay;  // alloc only
		sample_t  sample; // write only
		inc_t     inc;    // write only
	} host_cmd_t;

	typedef struct packed {
		resp_status_e status;
		sample_t      sample;
	} host_resp_t;

	typedef struct packed {
		logic    write_en;
		logic    read_en;
		addr_t   addr;
		sample_t data;
	} mem_req_t;

endpackage

`default_nettype wire

//--- src/sample_memory.sv
`default_nettype none

module sample_memory import delay_pkg::*; (
	input  wire       clk,
	input  wire       reset,
	input  wire       mem_req_t req,
	output logic      write_ack,
	output logic      read_valid,
	output sample_t   read_data
);

	sample_t ram [mem_depth];

	always_ff @(posedge clk) begin
		if (req.write_en) begin
			ram[req.addr] <= req.data;
		end
		if (req.read_en) begin
			read_data <= ram[req.addr]; // old data on same cycle
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			write_ack  <= 1'b0;
			read_valid <= 1'b0;
		end else begin
			write_ack  <= req.write_en;
			read_valid <= req.read_en;
		end
	end

	// requests arrive through the front end mux from one line at a time
	a_single_op: assert property (@(posedge clk) disable iff (reset)
		!(req.write_en && req.read_en));

endmodule

`default_nettype wire

//--- src/delay_line_ctrl.sv
`default_nettype none

module delay_line_ctrl import delay_pkg::*; (
	input  wire       clk,
	input  wire       reset,
	input  wire       init,
	input  wire       addr_t init_base,
	input  wire       addr_t init_size,
	input  wire       delay_t init_delay,
	input  wire       start,
	input  wire       sample_t sample_in,
	input  wire       inc_t inc,
	output mem_req_t  mem,
	input  wire       write_ack,
	input  wire       read_valid,
	input  wire       sample_t read_data,
	output logic      done,
	output sample_t   out_sample,
	output gain_t     gain
);

	line_state_e state;

	addr_t  base;
	addr_t  size;
	addr_t  position;
	addr_t  rd_addr;
	delay_t delay;
	logic   wrapped;
	gain_t  gain_acc;

	addr_t                     offset;
	logic [addr_w:0]           rel_pos;
	addr_t                     fetch_addr;
	delay_t                    max_delay;
	delay_t                    init_max;
	logic signed [delay_w+1:0] delay_sum;
	delay_t                    delay_clamped;

	////////////////////////////////////////
	// address and delay arithmetic

	assign offset = delay[frac_bits +: addr_w]; // integer part only

	assign rel_pos = (offset > position)
		? {1'b0, position} + {1'b0, size} - {1'b0, offset}
		: {1'b0, position} - {1'b0, offset};

	assign fetch_addr = base + rel_pos[addr_w-1:0];

	assign max_delay = delay_t'(size - 1'b1) << frac_bits;
	assign init_max  = delay_t'(init_size - 1'b1) << frac_bits;

	assign delay_sum = $signed({2'b00, delay}) + $signed({{2{inc[delay_w-1]}}, inc});

	always_comb begin
		if (delay_sum < 0) begin
			delay_clamped = '0;
		end else if (delay_sum > $signed({2'b00, max_delay})) begin
			delay_clamped = max_delay;
		end else begin
			delay_clamped = delay_sum[delay_w-1:0];
		end
	end

	////////////////////////////////////////
	// line FSM

	always_ff @(posedge clk) begin
		done         <= 1'b0;
		mem.write_en <= 1'b0;
		mem.read_en  <= 1'b0;
		if (reset) begin
			state    <= ls_idle;
			mem      <= '0;
			position <= '0;
			wrapped  <= 1'b0;
			gain_acc <= '0;
		end else if (init) begin
			state    <= ls_idle;
			base     <= init_base;
			size     <= init_size;
			delay    <= (init_delay > init_max) ? init_max : init_delay;
			position <= '0;
			wrapped  <= 1'b0;
			gain_acc <= '0; // fade in from silence
		end else begin
			case (state)
				ls_idle: begin
					if (start) begin
						mem.write_en <= 1'b1;
						mem.addr     <= base + position;
						mem.data     <= sample_in;
						rd_addr      <= fetch_addr; // uses delay before the increment
						delay        <= delay_clamped;
						state        <= ls_write;
					end
				end
				ls_write: begin
					if (write_ack) begin
						mem.read_en <= 1'b1;
						mem.addr    <= rd_addr;
						state       <= ls_fetch;
					end
				end
				ls_fetch: begin
					if (read_valid) begin
						out_sample <= read_data;
						gain       <= gain_acc; // gain before this update
						done       <= 1'b1;
						if (position == size - 1'b1) begin
							position <= '0;
							wrapped  <= 1'b1;
						end else begin
							position <= position + 1'b1;
						end
						if (wrapped && gain_acc < gain_t'(gain_unity)) begin
							gain_acc <= gain_acc + gain_t'(gain_step);
						end
						state <= ls_idle;
					end
				end
				default: state <= ls_idle;
			endcase
		end
	end

	a_addr_in_line: assert property (@(posedge clk) disable iff (reset)
		(mem.write_en || mem.read_en) |->
			({1'b0, mem.addr} >= {1'b0, base} &&
			 {1'b0, mem.addr} < {1'b0, base} + {1'b0, size}));

endmodule

`default_nettype wire

//--- src/command_front.sv
`default_nettype none

module command_front import delay_pkg::*; (
	input  wire                clk,
	input  wire                reset,
	input  wire                req,
	input  wire                host_cmd_t cmd,
	output logic               ack,
	output host_resp_t         resp,
	output logic [n_lines-1:0] line_init,
	output logic [n_lines-1:0] line_start,
	output addr_t              init_base,
	output addr_t              init_size,
	output delay_t             init_delay,
	input  wire                mem_req_t line_mem [n_lines],
	output mem_req_t           mem,
	input  wire  [n_lines-1:0] line_done,
	input  wire                sample_t line_sample [n_lines],
	input  wire                gain_t line_gain [n_lines],
	output logic               gain_valid,
	output sample_t            gain_sample,
	output gain_t              gain_value,
	input  wire                scaled_valid,
	input  wire                sample_t scaled_sample
);

	front_state_e state;

	logic                      req_q;
	line_id_t                  active;
	logic [$bits(line_id_t):0] alloc_count;
	logic [addr_w:0]           next_base;
	logic [addr_w:0]           alloc_end;
	line_id_t                  next_line;
	logic                      line_ok;
	logic                      alloc_fail;
	sample_t                   last_out [n_lines];

	assign alloc_end  = next_base + {1'b0, cmd.size};
	assign next_line  = alloc_count[$bits(line_id_t)-1:0];
	assign line_ok    = {1'b0, cmd.line} < alloc_count;
	assign alloc_fail = (alloc_count == ($bits(line_id_t)+1)'(n_lines)) ||
	                    (cmd.size == '0) ||
	                    (alloc_end > (addr_w+1)'(mem_depth));

	assign mem = line_mem[active]; // one command in flight

	always_ff @(posedge clk) begin
		line_init  <= '0;
		line_start <= '0;
		gain_valid <= 1'b0;
		if (reset) begin
			req_q       <= 1'b0;
			state       <= fs_idle;
			ack         <= 1'b0;
			active      <= '0;
			alloc_count <= '0;
			next_base   <= '0;
		end else begin
			req_q <= req;
			case (state)
				fs_idle: begin
					if (req_q) begin
						state       <= fs_ack;
						resp.status <= st_ok;
						resp.sample <= '0;
						case (cmd.op)
							op_alloc: begin
								if (alloc_fail) begin
									resp.status <= st_no_space;
								end else begin
									line_init[next_line] <= 1'b1;
									init_base            <= next_base[addr_w-1:0];
									init_size            <= cmd.size;
									init_delay           <= cmd.delay;
									last_out[next_line]  <= '0;
									resp.sample          <= sample_t'(alloc_count);
									alloc_count          <= alloc_count + 1'b1;
									next_base            <= alloc_end;
								end
							end
							op_write: begin
								if (!line_ok) begin
									resp.status <= st_bad_line;
								end else begin
									line_start[cmd.line] <= 1'b1;
									active               <= cmd.line;
									state                <= fs_wait_line;
								end
							end
							op_read: begin
								if (!line_ok) begin
									resp.status <= st_bad_line;
								end else begin
									resp.sample <= last_out[cmd.line];
								end
							end
							default: resp.status <= st_bad_line;
						endcase
					end
				end
				fs_wait_line: begin
					if (line_done[active]) begin
						gain_valid  <= 1'b1;
						gain_sample <= line_sample[active];
						gain_value  <= line_gain[active];
						state       <= fs_gain;
					end
				end
				fs_gain: begin
					if (scaled_valid) begin
						resp.sample      <= scaled_sample;
						last_out[active] <= scaled_sample;
						state            <= fs_ack;
					end
				end
				fs_ack: begin
					if (req_q) begin
						ack <= 1'b1; // held until the host drops req
					end else begin
						ack   <= 1'b0;
						state <= fs_idle;
					end
				end
				default: state <= fs_idle;
			endcase
		end
	end

	a_ack_after_req: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> $past(req));

endmodule

`default_nettype wire

//--- src/output_gain.sv
`default_nettype none

module output_gain import delay_pkg::*; (
	input  wire     clk,
	input  wire     reset,
	input  wire     valid_in,
	input  wire     sample_t sample_in,
	input  wire     gain_t gain,
	output logic    valid_out,
	output sample_t sample_out
);

	logic signed [2*sample_w:0] product;
	logic signed [2*sample_w:0] shifted;

	assign product = sample_in * $signed({1'b0, gain}); // gain is unsigned Q14
	assign shifted = product >>> gain_frac;

	always_ff @(posedge clk) begin
		if (shifted[2*sample_w:sample_w-1] != {(sample_w+2){shifted[2*sample_w]}}) begin
			sample_out <= shifted[2*sample_w] ? {1'b1, {(sample_w-1){1'b0}}}
			                                  : {1'b0, {(sample_w-1){1'b1}}};
		end else begin
			sample_out <= shifted[sample_w-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else begin
			valid_out <= valid_in;
		end
	end

endmodule

`default_nettype wire

//--- src/delay_engine.sv
`default_nettype none

module delay_engine import delay_pkg::*; (
	input  wire        clk,
	input  wire        reset,
	input  wire        req,
	input  wire        host_cmd_t cmd,
	output logic       ack,
	output host_resp_t resp
);

	logic [n_lines-1:0] line_init;
	logic [n_lines-1:0] line_start;
	logic [n_lines-1:0] line_done;
	addr_t              init_base;
	addr_t              init_size;
	delay_t             init_delay;
	mem_req_t           line_mem [n_lines];
	sample_t            line_sample [n_lines];
	gain_t              line_gain [n_lines];

	mem_req_t mem;
	logic     write_ack;
	logic     read_valid;
	sample_t  read_data;

	logic    gain_valid;
	sample_t gain_sample;
	gain_t   gain_value;
	logic    scaled_valid;
	sample_t scaled_sample;

	command_front front_i (
		.clk           (clk),
		.reset         (reset),
		.req           (req),
		.cmd           (cmd),
		.ack           (ack),
		.resp          (resp),
		.line_init     (line_init),
		.line_start    (line_start),
		.init_base     (init_base),
		.init_size     (init_size),
		.init_delay    (init_delay),
		.line_mem      (line_mem),
		.mem           (mem),
		.line_done     (line_done),
		.line_sample   (line_sample),
		.line_gain     (line_gain),
		.gain_valid    (gain_valid),
		.gain_sample   (gain_sample),
		.gain_value    (gain_value),
		.scaled_valid  (scaled_valid),
		.scaled_sample (scaled_sample)
	);

	sample_memory memory_i (
		.clk        (clk),
		.reset      (reset),
		.req        (mem),
		.write_ack  (write_ack),
		.read_valid (read_valid),
		.read_data  (read_data)
	);

	for (genvar i = 0; i < n_lines; i++) begin : g_line
		delay_line_ctrl line_i (
			.clk        (clk),
			.reset      (reset),
			.init       (line_init[i]),
			.init_base  (init_base),
			.init_size  (init_size),
			.init_delay (init_delay),
			.start      (line_start[i]),
			.sample_in  (cmd.sample), // host holds cmd until ack
			.inc        (cmd.inc),
			.mem        (line_mem[i]),
			.write_ack  (write_ack),
			.read_valid (read_valid),
			.read_data  (read_data),
			.done       (line_done[i]),
			.out_sample (line_sample[i]),
			.gain       (line_gain[i])
		);
	end

	output_gain gain_i (
		.clk        (clk),
		.reset      (reset),
		.valid_in   (gain_valid),
		.sample_in  (gain_sample),
		.gain       (gain_value),
		.valid_out  (scaled_valid),
		.sample_out (scaled_sample)
	);

endmodule

`default_nettype wire

//--- testbench/delay_vectors.svh
`ifndef delay_vectors_svh
`define delay_vectors_svh

// one row per command group with op, line, size, delay, inc, lcg flag, fixed sample,
// expected status, cycles req stays high after ack and repeat count

typedef struct packed {
	cmd_op_e      op;
	line_id_t     line;
	addr_t        size;
	delay_t       delay;
	inc_t         inc;
	logic         use_lcg;
	sample_t      sample;
	resp_status_e status;
	logic [3:0]   hold;
	logic [9:0]   count;
} vector_t;

localparam int n_vectors = 27;

localparam vector_t vectors [n_vectors] = '{
	'{op_write, 2'd0, 8'd0,   16'd0,     16'sd0,      1'b0, 16'sd0,     st_bad_line, 4'd2, 10'd1},
	'{op_read,  2'd1, 8'd0,   16'd0,     16'sd0,      1'b0, 16'sd0,     st_bad_line, 4'd0, 10'd1},
	'{op_alloc, 2'd0, 8'd0,   16'd0,     16'sd0,      1'b0, 16'sd0,     st_no_space, 4'd0, 10'd1},
	'{op_alloc, 2'd0, 8'd4,   16'd256,   16'sd0,      1'b0, 16'sd0,     st_ok,       4'd0, 10'd1},
	'{op_alloc, 2'd0, 8'd8,   16'hffff,  16'sd0,      1'b0, 16'sd0,     st_ok,       4'd3, 10'd1},
	'{op_write, 2'd2, 8'd0,   16'd0,     16'sd0,      1'b0, 16'sd0,     st_bad_line, 4'd0, 10'd1},
	'{op_alloc, 2'd0, 8'd250, 16'd0,     16'sd0,      1'b0, 16'sd0,     st_no_space, 4'd0, 10'd1},
	'{op_alloc, 2'd0, 8'd3,   16'd0,     16'sd0,      1'b0, 16'sd0,     st_ok,       4'd0, 10'd1},
	'{op_alloc, 2'd0, 8'd16,  16'd640,   16'sd0,      1'b0, 16'sd0,     st_ok,       4'd0, 10'd1},
	'{op_alloc, 2'd0, 8'd1,   16'd0,     16'sd0,      1'b0, 16'sd0,     st_no_space, 4'd0, 10'd1},
	'{op_read,  2'd3, 8'd0,   16'd0,     16'sd0,      1'b0, 16'sd0,     st_ok,       4'd0, 10'd1},
	// long run on line 0 so gain ramps all the way to unity
	'{op_write, 2'd0, 8'd0,   16'd0,     16'sd0,      1'b1, 16'sd0,     st_ok,       4'd0, 10'd300},
	'{op_read,  2'd0, 8'd0,   16'd0,     16'sd0,      1'b0, 16'sd0,     st_ok,       4'd1, 10'd1},
	'{op_write, 2'd0, 8'd0,   16'd0,     16'sd0,      1'b0, 16'sh7fff,  st_ok,       4'd0, 10'd2},
	'{op_write, 2'd0, 8'd0,   16'd0,     16'sd0,      1'b0, 16'sh8000,  st_ok,       4'd0, 10'd2},
	'{op_write, 2'd0, 8'd0,   16'd0,     16'sd0,      1'b0, -16'sd1,    st_ok,       4'd2, 10'd2},
	'{op_write, 2'd2, 8'd0,   16'd0,     16'sd0,      1'b1, 16'sd0,     st_ok,       4'd0, 10'd20},
	// clamping and interleaving between lines 1 and 3
	'{op_write, 2'd1, 8'd0,   16'd0,     16'sh7fff,   1'b1, 16'sd0,     st_ok,       4'd0, 10'd4},
	'{op_write, 2'd3, 8'd0,   16'd0,     16'sh8000,   1'b1, 16'sd0,     st_ok,       4'd0, 10'd4},
	'{op_write, 2'd1, 8'd0,   16'd0,     -16'sd300,   1'b1, 16'sd0,     st_ok,       4'd0, 10'd10},
	'{op_write, 2'd3, 8'd0,   16'd0,     16'sd200,    1'b1, 16'sd0,     st_ok,       4'd0, 10'd10},
	'{op_write, 2'd1, 8'd0,   16'd0,     16'sd0,      1'b1, 16'sd0,     st_ok,       4'd0, 10'd40},
	'{op_write, 2'd3, 8'd0,   16'd0,     16'sd37,     1'b1, 16'sd0,     st_ok,       4'd0, 10'd40},
	'{op_write, 2'd2, 8'd0,   16'd0,     16'sd0,      1'b1, 16'sd0,     st_ok,       4'd0, 10'd3},
	'{op_read,  2'd1, 8'd0,   16'd0,     16'sd0,      1'b0, 16'sd0,     st_ok,       4'd0, 10'd1},
	'{op_read,  2'd3, 8'd0,   16'd0,     16'sd0,      1'b0, 16'sd0,     st_ok,       4'd0, 10'd1},
	'{op_read,  2'd2, 8'd0,   16'd0,     16'sd0,      1'b0, 16'sd0,     st_ok,       4'd0, 10'd1}
};

`endif

//--- testbench/delay_engine_tb.sv
`default_nettype none

module delay_engine_tb import delay_pkg::*; ();

	localparam int wait_limit   = 100; // cycles per handshake phase
	localparam int fast_latency = 3;   // req registered on the next edge and ack two edges after

	logic       clk = 1'b0;
	logic       reset;
	logic       req;
	host_cmd_t  cmd;
	logic       ack;
	host_resp_t resp;

	logic [31:0] lcg_state;

	// reference model state
	int      m_size [n_lines];
	int      m_delay [n_lines];
	int      m_pos [n_lines];
	bit      m_wrapped [n_lines];
	int      m_gain [n_lines];
	sample_t m_last [n_lines];
	sample_t m_ring [n_lines][mem_depth];
	int      m_count;
	int      m_next_base;

	`include "delay_vectors.svh"

	delay_engine dut_i (
		.clk   (clk),
		.reset (reset),
		.req   (req),
		.cmd   (cmd),
		.ack   (ack),
		.resp  (resp)
	);

	always #20 clk = ~clk;

	////////////////////////////////////////
	// helpers

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic sample_t scale_sat(input sample_t x, input int g);
		longint p;
		p = (longint'(x) * longint'(g)) >>> 14; // Q14
		if (p > 32767) begin
			return 16'sh7fff;
		end else if (p < -32768) begin
			return 16'sh8000;
		end
		return sample_t'(p);
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string what, input logic signed [63:0] actual,
			input logic signed [63:0] expected);
		if (actual !== expected) begin
			abort_run($sformatf("FAIL at time %0t: %s is %0d, expected %0d",
				$time, what, actual, expected));
		end
	endtask

	////////////////////////////////////////
	// reference model

	task automatic model_reset();
		for (int l = 0; l < n_lines; l++) begin
			m_size[l]    = 0;
			m_delay[l]   = 0;
			m_pos[l]     = 0;
			m_wrapped[l] = 1'b0;
			m_gain[l]    = 0;
			m_last[l]    = '0;
			for (int a = 0; a < mem_depth; a++) begin
				m_ring[l][a] = '0;
			end
		end
		m_count     = 0;
		m_next_base = 0;
	endtask

	task automatic model_apply(input host_cmd_t c, output resp_status_e st, output sample_t s);
		int      l;
		int      off;
		int      rd;
		int      nd;
		int      dmax;
		int      old_gain;
		sample_t fetched;
		l  = int'(c.line);
		st = st_ok;
		s  = '0;
		case (c.op)
			op_alloc: begin
				dmax = (int'(c.size) - 1) << frac_bits;
				if (m_count == n_lines || c.size == 0 ||
				    m_next_base + int'(c.size) > mem_depth) begin
					st = st_no_space;
				end else begin
					m_size[m_count]    = int'(c.size);
					m_delay[m_count]   = (int'(c.delay) > dmax) ? dmax : int'(c.delay);
					m_pos[m_count]     = 0;
					m_wrapped[m_count] = 1'b0;
					m_gain[m_count]    = 0;
					m_last[m_count]    = '0;
					s = sample_t'(m_count);
					m_count++;
					m_next_base += int'(c.size);
				end
			end
			op_write: begin
				if (l >= m_count) begin
					st = st_bad_line;
				end else begin
					off = m_delay[l] >> frac_bits; // integer part only
					m_ring[l][m_pos[l]] = c.sample;
					rd = (m_pos[l] - off + m_size[l]) % m_size[l];
					fetched  = m_ring[l][rd];
					old_gain = m_gain[l];
					dmax = (m_size[l] - 1) << frac_bits;
					nd   = m_delay[l] + int'(c.inc);
					m_delay[l] = (nd < 0) ? 0 : ((nd > dmax) ? dmax : nd);
					if (m_wrapped[l] && m_gain[l] < gain_unity) begin
						m_gain[l] += gain_step;
					end
					m_pos[l]++;
					if (m_pos[l] == m_size[l]) begin
						m_pos[l]     = 0;
						m_wrapped[l] = 1'b1;
					end
					s = scale_sat(fetched, old_gain);
					m_last[l] = s;
				end
			end
			default: begin
				if (l >= m_count) begin
					st = st_bad_line;
				end else begin
					s = m_last[l];
				end
			end
		endcase
	endtask

	////////////////////////////////////////
	// host port

	task automatic run_command(input host_cmd_t c, input int hold, output host_resp_t r,
			output int latency);
		int cycles;
		@(posedge clk);
		#5;
		cmd = c;
		req = 1'b1;
		cycles = 0;
		while (!ack) begin
			if (cycles == wait_limit) begin
				abort_run("timeout: ack did not rise after req was raised");
			end
			@(posedge clk);
			#5;
			cycles++;
		end
		latency = cycles;
		r = resp;
		for (int i = 0; i < hold; i++) begin // back-pressure
			@(posedge clk);
			#5;
			check_value("ack while req held", 64'(ack), 64'(1'b1));
			check_value("resp while req held", 64'(resp), 64'(r));
		end
		req = 1'b0;
		cycles = 0;
		while (ack) begin
			if (cycles == wait_limit) begin
				abort_run("timeout: ack did not fall after req was dropped");
			end
			@(posedge clk);
			#5;
			cycles++;
		end
	endtask

	initial begin
		host_cmd_t    c;
		host_resp_t   r;
		resp_status_e exp_status;
		sample_t      exp_sample;
		int           latency;
		req       = 1'b0;
		cmd       = '0;
		reset     = 1'b1;
		lcg_state = 32'hf9ae4eb8;
		model_reset();
		repeat (10) @(posedge clk);
		#5;
		reset = 1'b0;
		check_value("ack after reset", 64'(ack), 64'(1'b0));
		for (int v = 0; v < n_vectors; v++) begin
			for (int k = 0; k < int'(vectors[v].count); k++) begin
				c       = '0;
				c.op    = vectors[v].op;
				c.line  = vectors[v].line;
				c.size  = vectors[v].size;
				c.delay = vectors[v].delay;
				c.inc   = vectors[v].inc;
				if (vectors[v].use_lcg) begin
					lcg_state = lcg_next(lcg_state);
					c.sample  = sample_t'(lcg_state[31:16]);
				end else begin
					c.sample = vectors[v].sample;
				end
				model_apply(c, exp_status, exp_sample);
				run_command(c, int'(vectors[v].hold), r, latency);
				check_value($sformatf("vector %0d status vs model", v),
					64'(r.status), 64'(exp_status));
				check_value($sformatf("vector %0d status vs table", v),
					64'(r.status), 64'(vectors[v].status));
				check_value($sformatf("vector %0d sample", v),
					64'(r.sample), 64'(exp_sample));
				if (c.op == op_alloc || exp_status != st_ok) begin
					check_value($sformatf("vector %0d ack latency", v),
						64'(latency), 64'(fast_latency));
				end
			end
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+testbench
src/delay_pkg.sv
src/sample_memory.sv
src/delay_line_ctrl.sv
src/command_front.sv
src/output_gain.sv
src/delay_engine.sv
testbench/delay_engine_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := delay_engine_tb
FILELIST  := list.f
BUILD_DIR := obj_dir
VFLAGS    := --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)
